// ==== source/arcade_pkg.sv ====
package arcade_pkg;

	// ======================================================================
	// Sizes fixed by the cabinet
	// ======================================================================
	localparam int KEY_QUEUE_DEPTH = 4;      // Queue size and host start credits
	localparam int KEY_PTR_BITS    = $clog2(KEY_QUEUE_DEPTH);
	localparam int KEY_COUNT_BITS  = KEY_PTR_BITS + 1;
	localparam int DAC_BITS        = 8;      // Audio sample width
	localparam int VGA_CHAN_BITS   = 6;      // Monitor colour depth per channel

	// ======================================================================
	// Keyboard
	// ======================================================================
	typedef struct packed {
		logic       pressed;  // 1 = make, 0 = break
		logic [7:0] code;
	} key_event_t;

	// PS/2 set 2 codes the cabinet listens to
	typedef enum logic [7:0] {
		KEY_UP          = 8'h75,
		KEY_DOWN        = 8'h72,
		KEY_LEFT        = 8'h6B,
		KEY_RIGHT       = 8'h74,
		KEY_COIN        = 8'h76,  // Esc
		KEY_ONE_PLAYER  = 8'h05,  // F1
		KEY_TWO_PLAYERS = 8'h06,  // F2
		KEY_FIRE3       = 8'h14,  // Ctrl
		KEY_FIRE2       = 8'h11,  // Alt
		KEY_FIRE1       = 8'h29   // Space
	} key_code_e;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic one_player;
		logic two_players;
		logic fire1;
		logic fire2;
		logic fire3;
	} button_set_t;

	// Bit 0 is right, as the host delivers it
	typedef struct packed {
		logic [1:0] spare;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// ======================================================================
	// Video
	// ======================================================================
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_core_t;

	typedef struct packed {
		logic [VGA_CHAN_BITS-1:0] r;
		logic [VGA_CHAN_BITS-1:0] g;
		logic [VGA_CHAN_BITS-1:0] b;
	} rgb_vga_t;

	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		DIM25    = 2'd1,
		DIM50    = 2'd2,
		DIM75    = 2'd3
	} scanline_e;

endpackage

// ==== source/key_decoder.sv ====
`timescale 1ns/10ps

module key_decoder (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    ce_6m,
	input  logic                    key_valid,
	input  arcade_pkg::key_event_t  key_event,
	output logic                    key_credit,
	output arcade_pkg::button_set_t buttons
);

	// ======================================================================
	// Event queue
	// ======================================================================
	arcade_pkg::key_event_t queue [arcade_pkg::KEY_QUEUE_DEPTH];

	logic [arcade_pkg::KEY_PTR_BITS-1:0]   wr_ptr;
	logic [arcade_pkg::KEY_PTR_BITS-1:0]   rd_ptr;
	logic [arcade_pkg::KEY_COUNT_BITS-1:0] count;
	arcade_pkg::key_event_t                head;
	logic                                  push;
	logic                                  pop;

	assign push = key_valid;                     // Host only pushes with credit
	assign pop  = ce_6m && (count != '0);        // Drain at pixel rate
	assign head = queue[rd_ptr];

	// Event storage
	always_ff @(posedge clk_sys) begin
		if (push) begin
			queue[wr_ptr] <= key_event;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;       // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// One credit back per pop on the cycle after the pop edge
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			key_credit <= 1'b0;
		else
			key_credit <= pop;
	end

	// ======================================================================
	// Scan code to button register
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			buttons <= '0;
		end else if (pop) begin
			case (arcade_pkg::key_code_e'(head.code))
				arcade_pkg::KEY_UP:          buttons.up          <= head.pressed;
				arcade_pkg::KEY_DOWN:        buttons.down        <= head.pressed;
				arcade_pkg::KEY_LEFT:        buttons.left        <= head.pressed;
				arcade_pkg::KEY_RIGHT:       buttons.right       <= head.pressed;
				arcade_pkg::KEY_COIN:        buttons.coin        <= head.pressed;
				arcade_pkg::KEY_ONE_PLAYER:  buttons.one_player  <= head.pressed;
				arcade_pkg::KEY_TWO_PLAYERS: buttons.two_players <= head.pressed;
				arcade_pkg::KEY_FIRE1:       buttons.fire1       <= head.pressed;
				arcade_pkg::KEY_FIRE2:       buttons.fire2       <= head.pressed;
				arcade_pkg::KEY_FIRE3:       buttons.fire3       <= head.pressed;
				default:                     buttons             <= buttons; // Unknown key
			endcase
		end
	end

endmodule

// ==== source/control_mapper.sv ====
`timescale 1ns/10ps

module control_mapper (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  arcade_pkg::button_set_t buttons,
	input  arcade_pkg::joy_t        joy0,
	input  arcade_pkg::joy_t        joy1,
	input  logic                    rotate,
	output logic [7:0]              in0,
	output logic [7:0]              in1
);

	// ======================================================================
	// Merge keyboard with both sticks
	// ======================================================================
	logic any_up;
	logic any_down;
	logic any_left;
	logic any_right;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	assign any_up    = buttons.up    | joy0.up    | joy1.up;
	assign any_down  = buttons.down  | joy0.down  | joy1.down;
	assign any_left  = buttons.left  | joy0.left  | joy1.left;
	assign any_right = buttons.right | joy0.right | joy1.right;

	// Quarter turn when rotate is low, for a sideways monitor
	always_comb begin
		if (!rotate) begin
			m_up    = any_left;
			m_down  = any_right;
			m_left  = any_down;
			m_right = any_up;
		end else begin
			m_up    = any_up;
			m_down  = any_down;
			m_left  = any_left;
			m_right = any_right;
		end
	end

	assign m_fire = buttons.fire1 | joy0.fire1 | joy1.fire1;

	// ======================================================================
	// Active-low input ports of the core
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			in0 <= 8'hFF;       // Nothing pressed
			in1 <= 8'hFF;
		end else begin
			in0 <= ~{2'b00, buttons.coin, 1'b0, m_down, m_right, m_left, m_up};
			in1 <= ~{1'b0, buttons.two_players, buttons.one_player, m_fire, 4'b0000};
		end
	end

endmodule

// ==== source/video_out.sv ====
`timescale 1ns/10ps

module video_out (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arcade_pkg::rgb_core_t pix,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic                  hblank,
	input  logic                  vblank,
	input  arcade_pkg::scanline_e scanlines,
	output arcade_pkg::rgb_vga_t  vga,
	output logic                  vga_hs,
	output logic                  vga_vs
);

	// Scanline attenuation of one channel
	function automatic logic [arcade_pkg::VGA_CHAN_BITS-1:0] dim_chan(
		input logic [arcade_pkg::VGA_CHAN_BITS-1:0] v,
		input arcade_pkg::scanline_e                mode
	);
		case (mode)
			arcade_pkg::DIM25: dim_chan = v - (v >> 2);  // Truncated three quarters
			arcade_pkg::DIM50: dim_chan = v >> 1;
			arcade_pkg::DIM75: dim_chan = v >> 2;
			default:           dim_chan = v;
		endcase
	endfunction

	logic                 hsync_d;
	logic                 line_odd;
	arcade_pkg::rgb_vga_t expanded;
	arcade_pkg::rgb_vga_t next_vga;

	// ======================================================================
	// Colour expansion and blanking
	// ======================================================================
	always_comb begin
		expanded.r = {pix.r, pix.r};              // 3 -> 6 bits
		expanded.g = {pix.g, pix.g};
		expanded.b = {pix.b, pix.b, pix.b};       // 2 -> 6 bits
		if (hblank || vblank) begin
			next_vga = '0;
		end else if (line_odd) begin
			next_vga.r = dim_chan(expanded.r, scanlines);
			next_vga.g = dim_chan(expanded.g, scanlines);
			next_vga.b = dim_chan(expanded.b, scanlines);
		end else begin
			next_vga = expanded;
		end
	end

	// Line parity flips on each hsync rising edge
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hsync_d  <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hsync_d <= hsync;
			if (hsync && !hsync_d)
				line_odd <= ~line_odd;
		end
	end

	// ======================================================================
	// Output registers
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vga    <= '0;
			vga_hs <= 1'b1;     // Inverted idle syncs
			vga_vs <= 1'b1;
		end else begin
			vga    <= next_vga;
			vga_hs <= ~hsync;   // Monitor wants the opposite polarity
			vga_vs <= ~vsync;
		end
	end

endmodule

// ==== source/sigma_delta_dac.sv ====
`timescale 1ns/10ps

module sigma_delta_dac (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [arcade_pkg::DAC_BITS-1:0] sample,
	output logic                          audio_bit
);

	// Top bit holds the carry of the last add
	logic [arcade_pkg::DAC_BITS:0] acc;

	// First order loop with a carry rate of sample / 256
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[arcade_pkg::DAC_BITS-1:0]} + {1'b0, sample};
	end

	assign audio_bit = acc[arcade_pkg::DAC_BITS];   // One bit per clock

endmodule

// ==== source/arcade_io_top.sv ====
`timescale 1ns/10ps

module arcade_io_top (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            ce_6m,
	// Host key events
	input  logic                            key_valid,
	input  arcade_pkg::key_event_t          key_event,
	output logic                            key_credit,
	// Controls
	input  arcade_pkg::joy_t                joy0,
	input  arcade_pkg::joy_t                joy1,
	input  logic                            rotate,
	output logic [7:0]                      in0,
	output logic [7:0]                      in1,
	// Core video and monitor
	input  arcade_pkg::rgb_core_t           pix,
	input  logic                            hsync,
	input  logic                            vsync,
	input  logic                            hblank,
	input  logic                            vblank,
	input  arcade_pkg::scanline_e           scanlines,
	output arcade_pkg::rgb_vga_t            vga,
	output logic                            vga_hs,
	output logic                            vga_vs,
	// Audio
	input  logic [arcade_pkg::DAC_BITS-1:0] sample,
	output logic                            audio_l
);

	arcade_pkg::button_set_t buttons;   // Keyboard state to the mapper

	// ======================================================================
	// Blocks
	// ======================================================================
	key_decoder key_decoder0 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ce_6m      (ce_6m),
		.key_valid  (key_valid),
		.key_event  (key_event),
		.key_credit (key_credit),
		.buttons    (buttons)
	);

	control_mapper control_mapper0 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.buttons (buttons),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (rotate),
		.in0     (in0),
		.in1     (in1)
	);

	video_out video_out0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.pix       (pix),
		.hsync     (hsync),
		.vsync     (vsync),
		.hblank    (hblank),
		.vblank    (vblank),
		.scanlines (scanlines),
		.vga       (vga),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac sigma_delta_dac0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sample    (sample),
		.audio_bit (audio_l)
	);

endmodule

// ==== testbench/arcade_io_props.sv ====
`timescale 1ns/10ps

module arcade_io_props (
	input logic                                  clk_sys,
	input logic                                  rst_n,
	input logic                                  key_valid,
	input logic                                  key_credit,
	input logic [arcade_pkg::KEY_COUNT_BITS-1:0] count
);

	// ======================================================================
	// Credit protocol of the key queue
	// ======================================================================
	no_push_when_full: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		key_valid |-> int'(count) < arcade_pkg::KEY_QUEUE_DEPTH
	) else $error("key event pushed into a full queue");

	credit_single_cycle: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		key_credit |=> !key_credit   // One credit per pop
	) else $error("key_credit high for two cycles in a row");

	credit_low_in_reset: assert property (
		@(posedge clk_sys) !rst_n |-> !key_credit
	) else $error("key_credit high during reset");

endmodule

bind key_decoder arcade_io_props props0 (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.key_valid  (key_valid),
	.key_credit (key_credit),
	.count      (count)
);

// ==== testbench/tb_arcade_io.sv ====
`timescale 1ns/10ps

module tb_arcade_io;

	logic                    clk_sys = 1'b0;
	logic                    rst_n;
	logic                    ce_6m;
	logic                    key_valid;
	arcade_pkg::key_event_t  key_event;
	logic                    key_credit;
	arcade_pkg::joy_t        joy0;
	arcade_pkg::joy_t        joy1;
	logic                    rotate;
	logic [7:0]              in0;
	logic [7:0]              in1;
	arcade_pkg::rgb_core_t   pix;
	logic                    hsync;
	logic                    vsync;
	logic                    hblank;
	logic                    vblank;
	arcade_pkg::scanline_e   scanlines;
	arcade_pkg::rgb_vga_t    vga;
	logic                    vga_hs;
	logic                    vga_vs;
	logic [7:0]              sample;
	logic                    audio_l;

	// ======================================================================
	// Reference model state
	// ======================================================================
	logic [7:0]              key_codes [10];        // In button_set_t field order
	arcade_pkg::key_event_t  model_q [$];
	arcade_pkg::button_set_t model_btn    = '0;
	logic                    model_odd    = 1'b0;   // Line parity
	logic                    model_hs_d   = 1'b0;
	logic                    check_ports  = 1'b0;
	logic [1:0]              ce_phase     = 2'd0;
	int unsigned             credits      = arcade_pkg::KEY_QUEUE_DEPTH;
	int unsigned             sent         = 0;
	int unsigned             returned     = 0;
	int unsigned             since_credit = 0;
	int unsigned             ones;
	int unsigned             err_key      = 0;
	int unsigned             err_ports    = 0;
	int unsigned             err_video    = 0;
	int unsigned             err_audio    = 0;

	arcade_io_top dut0 (.*);

	always #5 clk_sys = ~clk_sys;

	// Expected {in1, in0} from merged, optionally turned controls
	function automatic logic [15:0] expect_ports(
		arcade_pkg::button_set_t b, arcade_pkg::joy_t j0, arcade_pkg::joy_t j1, logic rot);
		logic u;
		logic d;
		logic l;
		logic r;
		logic f;
		u = b.up | j0.up | j1.up;
		d = b.down | j0.down | j1.down;
		l = b.left | j0.left | j1.left;
		r = b.right | j0.right | j1.right;
		f = b.fire1 | j0.fire1 | j1.fire1;
		if (!rot)   // Quarter turn
			return ~{1'b0, b.two_players, b.one_player, f, 4'b0, 2'b0, b.coin, 1'b0, r, u, d, l};
		return ~{1'b0, b.two_players, b.one_player, f, 4'b0, 2'b0, b.coin, 1'b0, d, r, l, u};
	endfunction

	function automatic logic [5:0] dim_expect(logic [5:0] v, arcade_pkg::scanline_e m, logic odd);
		if (!odd || m == arcade_pkg::SCAN_OFF)
			return v;
		if (m == arcade_pkg::DIM25)
			return v - v / 6'd4;
		if (m == arcade_pkg::DIM50)
			return v / 6'd2;
		return v / 6'd4;
	endfunction

	function automatic arcade_pkg::rgb_vga_t expect_vga(
		arcade_pkg::rgb_core_t p, logic blank, arcade_pkg::scanline_e m, logic odd);
		arcade_pkg::rgb_vga_t o;
		o.r = dim_expect({2{p.r}}, m, odd);
		o.g = dim_expect({2{p.g}}, m, odd);
		o.b = dim_expect({3{p.b}}, m, odd);
		if (blank)
			o = '0;
		return o;
	endfunction

	// One clock, then 1 ns of settling before checks and new inputs
	task automatic step();
		@(posedge clk_sys);
		#1;
		ce_phase = ce_phase + 1'b1;
		ce_6m    = (ce_phase == 2'd0);   // Every fourth cycle
	endtask

	task automatic compare_ports(logic [15:0] want);
		if (in0 !== want[7:0]) begin
			$display("mismatch in0 got %h expected %h", in0, want[7:0]);
			err_ports++;
		end
		if (in1 !== want[15:8]) begin
			$display("mismatch in1 got %h expected %h", in1, want[15:8]);
			err_ports++;
		end
	endtask

	// Host side of the key path after every step while keys are in flight
	task automatic track_keys();
		arcade_pkg::key_event_t ev;
		int                     k;
		if (check_ports) begin
			compare_ports(expect_ports(model_btn, '0, '0, 1'b1));
			check_ports = 1'b0;
		end
		if (key_credit) begin
			if (model_q.size() == 0) begin
				$display("key_credit pulse while no key event was queued");
				err_key++;
			end else begin
				ev = model_q.pop_front();
				for (k = 0; k < 10; k++)
					if (ev.code == key_codes[k])
						model_btn[9 - k] = ev.pressed;   // Unknown codes fall through
				check_ports = 1'b1;
			end
			credits++;
			returned++;
			since_credit = 0;
		end else if (model_q.size() != 0) begin
			since_credit++;
			if (since_credit > 16) begin
				$display("no key_credit within 16 clocks while events were queued");
				err_key++;
				since_credit = 0;
			end
		end else begin
			since_credit = 0;
		end
	endtask

	initial begin
		arcade_pkg::key_event_t ev;
		int                     wait_cnt;
		arcade_pkg::rgb_vga_t   want_vga;
		void'($urandom(32'h7737));
		key_codes = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h76, 8'h05, 8'h06, 8'h29, 8'h11, 8'h14};
		rst_n     = 1'b0;
		ce_6m     = 1'b0;
		key_valid = 1'b0;
		key_event = '0;
		joy0      = '0;
		joy1      = '0;
		rotate    = 1'b1;
		pix       = '0;
		hsync     = 1'b0;
		vsync     = 1'b0;
		hblank    = 1'b0;
		vblank    = 1'b0;
		scanlines = arcade_pkg::SCAN_OFF;
		sample    = '0;
		repeat (5) step();
		rst_n = 1'b1;

		// ==================================================================
		// Key events under credit flow control
		// ==================================================================
		repeat (600) begin
			step();
			track_keys();
			if (credits > 0 && $urandom_range(0, 2) != 0) begin
				ev.pressed = 1'($urandom);
				ev.code    = ($urandom_range(0, 3) == 0) ? 8'($urandom)
				                                         : key_codes[$urandom_range(0, 9)];
				key_valid  = 1'b1;
				key_event  = ev;
				model_q.push_back(ev);
				credits--;
				sent++;
			end else begin
				key_valid = 1'b0;
			end
		end
		step();   // Last event enters the queue
		track_keys();
		key_valid = 1'b0;
		wait_cnt  = 0;
		while ((model_q.size() != 0 || check_ports) && wait_cnt < 200) begin
			step();
			track_keys();
			wait_cnt++;
		end
		if (wait_cnt >= 200) begin
			$display("key queue did not drain within 200 clocks");
			err_key++;
		end
		repeat (8) begin   // Catch stray credits
			step();
			track_keys();
		end
		if (returned != sent) begin
			$display("mismatch key_credit pulses got %h expected %h", returned, sent);
			err_key++;
		end

		// ==================================================================
		// Joysticks, rotation, video and audio
		// ==================================================================
		repeat (200) begin
			joy0   = 8'($urandom);
			joy1   = 8'($urandom);
			rotate = 1'($urandom);
			step();
			compare_ports(expect_ports(model_btn, joy0, joy1, rotate));
		end
		repeat (300) begin
			pix       = 8'($urandom);
			hsync     = ($urandom_range(0, 3) == 0);
			vsync     = 1'($urandom);
			hblank    = ($urandom_range(0, 7) == 0);
			vblank    = ($urandom_range(0, 7) == 0);
			scanlines = arcade_pkg::scanline_e'(2'($urandom));
			step();
			want_vga = expect_vga(pix, hblank | vblank, scanlines, model_odd);
			if (vga !== want_vga) begin
				$display("mismatch vga got %h expected %h", vga, want_vga);
				err_video++;
			end
			if (vga_hs !== ~hsync || vga_vs !== ~vsync) begin
				$display("mismatch vga_hs/vga_vs got %h/%h expected %h/%h",
				         vga_hs, vga_vs, ~hsync, ~vsync);
				err_video++;
			end
			if (hsync && !model_hs_d)
				model_odd = ~model_odd;
			model_hs_d = hsync;
		end
		repeat (6) begin
			sample = 8'($urandom);
			ones   = 0;
			repeat (256) begin
				step();
				if (audio_l)
					ones++;
			end
			if (ones != 32'(sample)) begin
				$display("mismatch audio_l ones got %h expected %h", ones, sample);
				err_audio++;
			end
		end

		$display("errors: key %0d ports %0d video %0d audio %0d",
		         err_key, err_ports, err_video, err_audio);
		if (err_key + err_ports + err_video + err_audio == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/arcade_pkg.sv
source/key_decoder.sv
source/control_mapper.sv
source/video_out.sv
source/sigma_delta_dac.sv
source/arcade_io_top.sv
testbench/arcade_io_props.sv
testbench/tb_arcade_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arcade I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_arcade_io -f vlog.f -o tb_arcade_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_arcade_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0
